// ==== build.f ====
+incdir+design
design/vg_pkg.sv
design/vg_cmd_issue.sv
design/vg_pad_align.sv
design/vg_window.sv
design/vg_stride_select.sv
design/vectorgen.sv
verif/vectorgen_props.sv
verif/vectorgen_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module vectorgen_tb -o vectorgen_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/vectorgen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== verif/vectorgen_tb.sv ====
// expected vectors come from a stream model of the table; padding changes only between rows
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vectorgen_tb;

  localparam int EW        = `VG_ELEM_W;
  localparam int WORD_W    = `VG_LANES * `VG_ELEM_W;
  localparam int MAX_ITEMS = 64;
  localparam int TIMEOUT   = 200;

  logic                 clk = 1'b0;
  logic                 reset;
  logic [`VG_CMD_W-1:0] cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [WORD_W-1:0]    in_data;
  logic                 in_valid;
  logic                 in_ready;
  logic [WORD_W-1:0]    out_data;
  logic                 out_valid;
  logic                 out_ready = 1'b0;

  integer seed = 32'h3dec953a;
  int     error_count = 0;
  int     timeout_count = 0;

  // stimulus table and the expected vectors
  logic [`VG_CMD_W-1:0] stim_cmd [0:MAX_ITEMS-1];
  logic [WORD_W-1:0]    stim_data [0:MAX_ITEMS-1];
  int                   stim_count = 0;
  logic [WORD_W-1:0]    exp_out [0:MAX_ITEMS-1];
  int                   exp_count = 0;
  logic [EW-1:0]        elem_next = 16'h0101;

  vectorgen i_vectorgen (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

  always #10 clk = ~clk;

  // random back-pressure with ready about three cycles in four
  always @(posedge clk)
    out_ready <= (($random(seed) & 3) != 0);

  task automatic check_value(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string what);
    if (got !== exp)
    begin
      error_count++;
      $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_item(input logic [`VG_CMD_W-1:0] word, input logic [WORD_W-1:0] data);
    stim_cmd[stim_count]  = word;
    stim_data[stim_count] = data;
    stim_count++;
  endtask

  task automatic add_cfg(input logic [1:0] stride, input logic [1:0] pad);
    add_item({1'b1, stride, pad, 3'b000}, '0);
  endtask

  // pops get fresh words of consecutive element values
  task automatic add_op(input logic [1:0] code, input int count);
    logic [WORD_W-1:0] word;
    for (int n = 0; n < count; n++)
    begin
      word = '0;
      if (code == vg_pkg::op_pop)
      begin
        for (int i = 0; i < `VG_LANES; i++)
        begin
          word[i*EW +: EW] = elem_next;
          elem_next = elem_next + 1'b1;
        end
      end
      add_item({1'b0, code, 5'b00000}, word);
    end
  endtask

  //**********************************************************************
  // reference model
  //**********************************************************************
  task automatic build_expected();
    logic [EW-1:0]        win_m [0:`VG_WIN_ELEMS-1];
    logic [EW-1:0]        pend_q [$];
    logic [EW-1:0]        grp [0:`VG_LANES-1];
    logic [`VG_CMD_W-1:0] c;
    int                   stride_m;
    int                   pad_m;
    bit                   fresh;
    stride_m = 1;
    pad_m    = 0;
    fresh    = 1'b1;
    foreach (win_m[k])
      win_m[k] = '0;
    for (int i = 0; i < stim_count; i++)
    begin
      c = stim_cmd[i];
      if (c[7])
      begin
        stride_m = (c[6:5] == vg_pkg::stride_4) ? 4 : (c[6:5] == vg_pkg::stride_2) ? 2 : 1;
        pad_m    = int'(c[4:3]);
      end
      else if (c[6:5] == vg_pkg::op_row_start)
      begin
        foreach (win_m[k])
          win_m[k] = '0;
        pend_q.delete();
        fresh = 1'b1;
      end
      else
      begin
        if (c[6:5] == vg_pkg::op_shift)
        begin
          for (int k = 0; k < `VG_WIN_ELEMS - 1; k++)
            win_m[k] = win_m[k+1];
          win_m[`VG_WIN_ELEMS-1] = '0;
        end
        else
        begin
          // row stream is left padding, then words, then zeros at end row
          if (c[6:5] == vg_pkg::op_pop)
          begin
            if (fresh)
            begin
              for (int p = 0; p < pad_m; p++)
                pend_q.push_back('0);
            end
            fresh = 1'b0;
            for (int j = 0; j < `VG_LANES; j++)
              pend_q.push_back(stim_data[i][j*EW +: EW]);
          end
          for (int g = 0; g < `VG_LANES; g++)
            grp[g] = (pend_q.size() > 0) ? pend_q.pop_front() : '0;
          if (c[6:5] == vg_pkg::op_end_row)
          begin
            pend_q.delete();
            fresh = 1'b1;
          end
          for (int k = 0; k < `VG_WIN_ELEMS - `VG_LANES; k++)
            win_m[k] = win_m[k+`VG_LANES];
          for (int g = 0; g < `VG_LANES; g++)
            win_m[`VG_WIN_ELEMS-`VG_LANES+g] = grp[g];
        end
        for (int g = 0; g < `VG_LANES; g++)
          exp_out[exp_count][g*EW +: EW] = win_m[stride_m*g];
        exp_count++;
      end
    end
  endtask

  //**********************************************************************
  // driver and monitor
  //**********************************************************************
  task automatic drive_table();
    bit accepted;
    bit is_pop;
    int waited;
    for (int i = 0; i < stim_count && timeout_count == 0; i++)
    begin
      is_pop = !stim_cmd[i][7] && (stim_cmd[i][6:5] == vg_pkg::op_pop);
      cmd       <= stim_cmd[i];
      cmd_valid <= 1'b1;
      in_data   <= stim_data[i];
      in_valid  <= is_pop;
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && waited < TIMEOUT)
      begin
        @(negedge clk);
        if (cmd_ready)
        begin
          accepted = 1'b1;
          check_value(WORD_W'(in_ready), WORD_W'(is_pop), $sformatf("in_ready, command %0d", i));
        end
        waited++;
        @(posedge clk);
      end
      if (!accepted)
      begin
        $display("timeout: command %0d was not accepted within %0d cycles", i, TIMEOUT);
        timeout_count++;
      end
    end
    cmd_valid <= 1'b0;
    in_valid  <= 1'b0;
  endtask

  // transfer seen at a falling edge happens on the next rising edge
  task automatic collect_outputs();
    bit got;
    int waited;
    for (int k = 0; k < exp_count && timeout_count == 0; k++)
    begin
      got    = 1'b0;
      waited = 0;
      while (!got && waited < TIMEOUT)
      begin
        @(negedge clk);
        if (out_valid && out_ready)
        begin
          got = 1'b1;
          check_value(out_data, exp_out[k], $sformatf("output vector %0d", k));
        end
        waited++;
      end
      if (!got)
      begin
        $display("timeout: output vector %0d did not arrive within %0d cycles", k, TIMEOUT);
        timeout_count++;
      end
    end
    // nothing may follow the last expected vector
    repeat (20)
    begin
      @(negedge clk);
      check_value(WORD_W'(out_valid), '0, "out_valid after the last vector");
    end
  endtask

  initial
  begin
    reset     = 1'b1;
    // a pop with its word is offered while reset is held
    cmd       = {1'b0, vg_pkg::op_pop, 5'b00000};
    cmd_valid = 1'b1;
    in_data   = '1;
    in_valid  = 1'b1;

    add_op(vg_pkg::op_row_start, 1);
    add_op(vg_pkg::op_pop, 4);
    add_op(vg_pkg::op_end_row, 1);
    add_cfg(vg_pkg::stride_1, 2'd1);
    add_op(vg_pkg::op_pop, 3);
    add_op(vg_pkg::op_end_row, 1);
    add_cfg(vg_pkg::stride_1, 2'd2);
    add_op(vg_pkg::op_pop, 3);
    add_op(vg_pkg::op_end_row, 1);
    add_cfg(vg_pkg::stride_1, 2'd3);
    add_op(vg_pkg::op_pop, 3);
    add_op(vg_pkg::op_end_row, 1);
    add_cfg(vg_pkg::stride_2, 2'd0);
    add_op(vg_pkg::op_row_start, 1);
    add_op(vg_pkg::op_pop, 4);
    // stride change in the middle of a row
    add_cfg(vg_pkg::stride_4, 2'd0);
    add_op(vg_pkg::op_pop, 2);
    add_op(vg_pkg::op_shift, 3);
    add_op(vg_pkg::op_end_row, 1);
    // row start while a carry is pending
    add_cfg(vg_pkg::stride_1, 2'd2);
    add_op(vg_pkg::op_pop, 2);
    add_op(vg_pkg::op_row_start, 1);
    add_op(vg_pkg::op_pop, 2);
    add_op(vg_pkg::op_end_row, 1);
    build_expected();

    repeat (10) @(posedge clk);
    reset     <= 1'b0;
    cmd_valid <= 1'b0;
    in_valid  <= 1'b0;
    @(posedge clk);
    fork
      drive_table();
      collect_outputs();
    join

    $display("errors: %0d, timeouts: %0d, expected vectors: %0d",
             error_count, timeout_count, exp_count);
    if (error_count == 0 && timeout_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/vectorgen_props.sv ====
// port level checks only; the reset check starts from the second reset edge
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vectorgen_props (
  input logic                            clk,
  input logic                            reset,
  input logic                            cmd_ready,
  input logic                            in_ready,
  input logic [`VG_LANES*`VG_ELEM_W-1:0] out_data,
  input logic                            out_valid,
  input logic                            out_ready
);

  // a held vector stays put until it is taken
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_valid or out_data changed while out_ready was low");

  // input words are only taken together with a pop
  a_in_with_cmd: assert property (@(posedge clk) disable iff (reset)
    in_ready |-> cmd_ready)
    else $error("in_ready high without cmd_ready");

  a_reset_quiet: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!out_valid && !cmd_ready && !in_ready))
    else $error("handshake signal high during reset");

endmodule

bind vectorgen vectorgen_props i_vectorgen_props (
  .clk(clk), .reset(reset), .cmd_ready(cmd_ready), .in_ready(in_ready),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
);

`default_nettype wire

// ==== design/vectorgen.sv ====
// four stage pipeline; a vector held at the output stalls every stage until out_ready
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vectorgen (
  input  logic                            clk,
  input  logic                            reset,
  input  vg_pkg::vg_cmd_u                 cmd,
  input  logic                            cmd_valid,
  output logic                            cmd_ready,
  input  logic [`VG_LANES*`VG_ELEM_W-1:0] in_data,
  input  logic                            in_valid,
  output logic                            in_ready,
  output logic [`VG_LANES*`VG_ELEM_W-1:0] out_data,
  output logic                            out_valid,
  input  logic                            out_ready
);

  logic                                stall;

  // issue to align
  logic                                op_valid;
  vg_pkg::vg_op_e                      op;
  vg_pkg::vg_stride_e                  op_stride;
  logic [1:0]                          op_padding;
  logic [`VG_LANES*`VG_ELEM_W-1:0]     op_data;

  // align to window
  logic                                aligned_valid;
  vg_pkg::vg_op_e                      aligned_op;
  vg_pkg::vg_stride_e                  aligned_stride;
  logic [`VG_LANES*`VG_ELEM_W-1:0]     aligned_data;

  // window to lane pick
  logic                                win_valid;
  vg_pkg::vg_stride_e                  win_stride;
  logic [`VG_WIN_ELEMS*`VG_ELEM_W-1:0] win;

  // one global stall
  assign stall = out_valid && !out_ready;

  vg_cmd_issue i_cmd_issue (
    .clk(clk), .reset(reset), .stall(stall),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .op_valid(op_valid), .op(op), .op_stride(op_stride),
    .op_padding(op_padding), .op_data(op_data)
  );

  vg_pad_align i_pad_align (
    .clk(clk), .reset(reset), .stall(stall),
    .op_valid(op_valid), .op(op), .op_stride(op_stride),
    .op_padding(op_padding), .op_data(op_data),
    .aligned_valid(aligned_valid), .aligned_op(aligned_op),
    .aligned_stride(aligned_stride), .aligned_data(aligned_data)
  );

  vg_window i_window (
    .clk(clk), .reset(reset), .stall(stall),
    .aligned_valid(aligned_valid), .aligned_op(aligned_op),
    .aligned_stride(aligned_stride), .aligned_data(aligned_data),
    .win_valid(win_valid), .win_stride(win_stride), .win(win)
  );

  vg_stride_select i_stride_select (
    .clk(clk), .reset(reset),
    .win_valid(win_valid), .win_stride(win_stride), .win(win),
    .out_ready(out_ready), .out_data(out_data), .out_valid(out_valid)
  );

endmodule

`default_nettype wire

// ==== design/vg_stride_select.sv ====
// output register loads whenever it is empty or being taken; stride code 3 falls back to stride 1
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vg_stride_select (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                win_valid,
  input  vg_pkg::vg_stride_e                  win_stride,
  input  logic [`VG_WIN_ELEMS*`VG_ELEM_W-1:0] win,
  input  logic                                out_ready,
  output logic [`VG_LANES*`VG_ELEM_W-1:0]     out_data,
  output logic                                out_valid
);

  localparam int EW = `VG_ELEM_W;

  logic                          load;
  int                            step;
  logic [`VG_LANES*EW-1:0]       picked;

  assign load = !out_valid || out_ready;

  // lane g reads window position step*g
  always_comb
  begin
    case (win_stride)
      vg_pkg::stride_2: step = 2;
      vg_pkg::stride_4: step = 4;
      default:          step = 1;
    endcase
    for (int g = 0; g < `VG_LANES; g++)
      picked[g*EW +: EW] = win[(g*step)*EW +: EW];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else if (load)
      out_valid <= win_valid;
  end

  always_ff @(posedge clk)
  begin
    if (load && win_valid)
      out_data <= picked;
  end

endmodule

`default_nettype wire

// ==== design/vg_window.sv ====
// window position 0 is the lowest element; new data always enters at the top four positions
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vg_window (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stall,
  input  logic                                aligned_valid,
  input  vg_pkg::vg_op_e                      aligned_op,
  input  vg_pkg::vg_stride_e                  aligned_stride,
  input  logic [`VG_LANES*`VG_ELEM_W-1:0]     aligned_data,
  output logic                                win_valid,
  output vg_pkg::vg_stride_e                  win_stride,
  output logic [`VG_WIN_ELEMS*`VG_ELEM_W-1:0] win
);

  localparam int EW    = `VG_ELEM_W;
  localparam int WIN_W = `VG_WIN_ELEMS * `VG_ELEM_W;
  localparam int WORD_W = `VG_LANES * `VG_ELEM_W;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      win_valid <= 1'b0;
      win       <= '0;
    end
    else if (!stall)
    begin
      // row start updates the window but yields no vector
      win_valid <= aligned_valid && (aligned_op != vg_pkg::op_row_start);
      if (aligned_valid)
      begin
        case (aligned_op)
          vg_pkg::op_row_start: win <= '0;
          vg_pkg::op_shift:     win <= {{EW{1'b0}}, win[WIN_W-1:EW]};
          default:              win <= {aligned_data, win[WIN_W-1:WORD_W]};
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (aligned_valid && !stall)
      win_stride <= aligned_stride;
  end

endmodule

`default_nettype wire

// ==== design/vg_pad_align.sv ====
// padding count is taken per op; a change of padding inside a row mixes stale carry elements
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vg_pad_align (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            stall,
  input  logic                            op_valid,
  input  vg_pkg::vg_op_e                  op,
  input  vg_pkg::vg_stride_e              op_stride,
  input  logic [1:0]                      op_padding,
  input  logic [`VG_LANES*`VG_ELEM_W-1:0] op_data,
  output logic                            aligned_valid,
  output vg_pkg::vg_op_e                  aligned_op,
  output vg_pkg::vg_stride_e              aligned_stride,
  output logic [`VG_LANES*`VG_ELEM_W-1:0] aligned_data
);

  localparam int EW = `VG_ELEM_W;
  localparam int CARRY_ELEMS = `VG_LANES - 1;

  logic [CARRY_ELEMS*EW-1:0]   carry;
  logic [`VG_LANES*EW-1:0]     carry_ext;
  logic [`VG_LANES*EW-1:0]     next_word;
  logic [CARRY_ELEMS*EW-1:0]   next_carry;

  // extra zero element keeps the lane loop in range
  assign carry_ext = {{EW{1'b0}}, carry};

  // carry first, then the word; end row fills with zeros
  always_comb
  begin
    next_word  = '0;
    next_carry = '0;
    for (int i = 0; i < `VG_LANES; i++)
    begin
      if (i < int'(op_padding))
        next_word[i*EW +: EW] = carry_ext[i*EW +: EW];
      else if (op == vg_pkg::op_pop)
        next_word[i*EW +: EW] = op_data[(i - int'(op_padding))*EW +: EW];
    end
    // top elements of a popped word wait for the next group
    for (int j = 0; j < CARRY_ELEMS; j++)
    begin
      if (op == vg_pkg::op_pop && j < int'(op_padding))
        next_carry[j*EW +: EW] = op_data[(`VG_LANES - int'(op_padding) + j)*EW +: EW];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      aligned_valid <= 1'b0;
      carry         <= '0;
    end
    else if (!stall)
    begin
      aligned_valid <= op_valid;
      // shift leaves the carry alone, row start and end row empty it
      if (op_valid && op != vg_pkg::op_shift)
        carry <= next_carry;
    end
  end

  always_ff @(posedge clk)
  begin
    if (op_valid && !stall)
    begin
      aligned_op     <= op;
      aligned_stride <= op_stride;
      aligned_data   <= next_word;
    end
  end

endmodule

`default_nettype wire

// ==== design/vg_cmd_issue.sv ====
// a pop is taken only together with an input word; nothing is taken while the pipeline stalls
`default_nettype none
`timescale 1ns/10ps
`include "vg_params.svh"

module vg_cmd_issue (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            stall,
  input  vg_pkg::vg_cmd_u                 cmd,
  input  logic                            cmd_valid,
  output logic                            cmd_ready,
  input  logic [`VG_LANES*`VG_ELEM_W-1:0] in_data,
  input  logic                            in_valid,
  output logic                            in_ready,
  output logic                            op_valid,
  output vg_pkg::vg_op_e                  op,
  output vg_pkg::vg_stride_e              op_stride,
  output logic [1:0]                      op_padding,
  output logic [`VG_LANES*`VG_ELEM_W-1:0] op_data
);

  logic               is_cfg;
  logic               is_pop;
  logic               take_op;
  vg_pkg::vg_stride_e cfg_stride;
  logic [1:0]         cfg_padding;

  // kind bit is shared by both views of the word
  assign is_cfg = cmd.cfg_v.kind;
  assign is_pop = !is_cfg && (cmd.op_v.op == vg_pkg::op_pop);

  // pop needs the input word in the same cycle; nothing is taken in reset
  assign cmd_ready = cmd_valid && !reset && !stall && (!is_pop || in_valid);
  assign in_ready  = cmd_valid && in_valid && !reset && !stall && is_pop;
  assign take_op   = cmd_ready && !is_cfg;

  //********************************************************************
  // stored configuration
  //********************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg_stride  <= vg_pkg::stride_1;
      cfg_padding <= 2'd0;
    end
    else if (cmd_ready && is_cfg)
    begin
      cfg_stride  <= cmd.cfg_v.stride;
      cfg_padding <= cmd.cfg_v.padding;
    end
  end

  //********************************************************************
  // issue register
  //********************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
      op_valid <= 1'b0;
    else if (!stall)
      op_valid <= take_op;
  end

  // config in force at acceptance travels with the op
  always_ff @(posedge clk)
  begin
    if (take_op)
    begin
      op         <= cmd.op_v.op;
      op_stride  <= cfg_stride;
      op_padding <= cfg_padding;
      op_data    <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/vg_pkg.sv ====
// command word layout is fixed at 8 bits with the kind bit in the msb; stride code 3 is unused
`default_nettype none
`include "vg_params.svh"

package vg_pkg;

  // operation codes carried by an operation command
  typedef enum logic [1:0] {
    op_pop       = 2'd0,
    op_shift     = 2'd1,
    op_end_row   = 2'd2,
    op_row_start = 2'd3
  } vg_op_e;

  // lane spacing in window elements
  typedef enum logic [1:0] {
    stride_1 = 2'd0,
    stride_2 = 2'd1,
    stride_4 = 2'd2
  } vg_stride_e;

  // kind = 1, stride and padding update
  typedef struct packed {
    logic               kind;
    vg_stride_e         stride;
    logic [1:0]         padding;
    logic [`VG_CMD_W-6:0] spare;
  } vg_cfg_view_t;

  // kind = 0, one pipeline operation
  typedef struct packed {
    logic               kind;
    vg_op_e             op;
    logic [`VG_CMD_W-4:0] spare;
  } vg_op_view_t;

  typedef union packed {
    vg_cfg_view_t cfg_v;
    vg_op_view_t  op_v;
  } vg_cmd_u;

endpackage

`default_nettype wire

// ==== design/vg_params.svh ====
// sizes are fixed by the datapath: four lanes of 16 bits, a 16 element window, 8 bit commands
`ifndef VG_PARAMS_SVH
`define VG_PARAMS_SVH

// bits per feature-map element
`define VG_ELEM_W 16

// elements per input word and per output vector
`define VG_LANES 4

// elements held in the sliding window
`define VG_WIN_ELEMS 16

// bits per command word
`define VG_CMD_W 8

`endif
